/* hw/sys_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths, RAM depth, memory map and timer register offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SYS_DEFINES_SVH
`define SYS_DEFINES_SVH

// Bus data and address width
`define SYS_DATA_W 32

// RAM depth in words
`define SYS_RAM_WORDS 1024

// Memory map, each window is base plus mask
`define SYS_RAM_BASE     32'h0010_0000
`define SYS_RAM_MASK     32'hFFFF_F000
`define SYS_SIMCTRL_BASE 32'h0002_0000
`define SYS_SIMCTRL_MASK 32'hFFFF_FC00
`define SYS_TIMER_BASE   32'h0003_0000
`define SYS_TIMER_MASK   32'hFFFF_FC00

`define SYS_NR_HOSTS   2
`define SYS_NR_DEVICES 3

// Timer register offsets within its window
`define SYS_TIMER_MTIME_LO    32'h0000_0000
`define SYS_TIMER_MTIME_HI    32'h0000_0004
`define SYS_TIMER_MTIMECMP_LO 32'h0000_0008
`define SYS_TIMER_MTIMECMP_HI 32'h0000_000C

`endif

/* hw/sys_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared bus word type and index enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "sys_defines.svh"

package sys_pkg;

  // One bus data or address word
  typedef logic [`SYS_DATA_W-1:0] word_t;

  // Host ports, lower index has priority
  typedef enum logic {
    HostCore,
    HostDebug
  } bus_host_e;

  // Devices behind the address decoder
  typedef enum logic [1:0] {
    DevRam,
    DevSimCtrl,
    DevTimer
  } bus_device_e;

  // Timer register selects
  typedef enum logic [1:0] {
    MtimeLo,
    MtimeHi,
    MtimecmpLo,
    MtimecmpHi
  } timer_reg_e;

endpackage

/* hw/bus.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host arbiter, address decoder and response router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sys_defines.svh"

module bus (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     host_req_i    [`SYS_NR_HOSTS],
  input  sys_pkg::word_t           host_addr_i   [`SYS_NR_HOSTS],
  input  logic                     host_we_i     [`SYS_NR_HOSTS],
  input  logic [`SYS_DATA_W/8-1:0] host_be_i     [`SYS_NR_HOSTS],
  input  sys_pkg::word_t           host_wdata_i  [`SYS_NR_HOSTS],
  output logic                     host_gnt_o    [`SYS_NR_HOSTS],
  output logic                     host_rvalid_o [`SYS_NR_HOSTS],
  output sys_pkg::word_t           host_rdata_o  [`SYS_NR_HOSTS],
  output logic                     host_err_o    [`SYS_NR_HOSTS],
  output logic                     dev_req_o     [`SYS_NR_DEVICES],
  output sys_pkg::word_t           dev_addr_o    [`SYS_NR_DEVICES],
  output logic                     dev_we_o      [`SYS_NR_DEVICES],
  output logic [`SYS_DATA_W/8-1:0] dev_be_o      [`SYS_NR_DEVICES],
  output sys_pkg::word_t           dev_wdata_o   [`SYS_NR_DEVICES],
  input  logic                     dev_rvalid_i  [`SYS_NR_DEVICES],
  input  sys_pkg::word_t           dev_rdata_i   [`SYS_NR_DEVICES],
  input  logic                     dev_err_i     [`SYS_NR_DEVICES]
);
  import sys_pkg::*;

  word_t       dev_base [`SYS_NR_DEVICES];
  word_t       dev_mask [`SYS_NR_DEVICES];
  logic        arb_req;
  bus_host_e   host_sel;
  logic        dec_hit;
  bus_device_e dev_sel;
  logic        rsp_valid_q;
  bus_host_e   rsp_host_q;
  logic        rsp_hit_q;
  bus_device_e rsp_dev_q;

  // Memory map
  assign dev_base[DevRam]     = `SYS_RAM_BASE;
  assign dev_mask[DevRam]     = `SYS_RAM_MASK;
  assign dev_base[DevSimCtrl] = `SYS_SIMCTRL_BASE;
  assign dev_mask[DevSimCtrl] = `SYS_SIMCTRL_MASK;
  assign dev_base[DevTimer]   = `SYS_TIMER_BASE;
  assign dev_mask[DevTimer]   = `SYS_TIMER_MASK;

  // Fixed priority, scan from the lowest priority so host 0 wins last
  always_comb begin
    arb_req  = 1'b0;
    host_sel = HostCore;
    for (int h = `SYS_NR_HOSTS - 1; h >= 0; h--) begin
      if (host_req_i[h]) begin
        arb_req  = 1'b1;
        host_sel = bus_host_e'(h);
      end
    end
  end

  // Address decode of the winning host
  always_comb begin
    dec_hit = 1'b0;
    dev_sel = DevRam;
    for (int d = 0; d < `SYS_NR_DEVICES; d++) begin
      if ((host_addr_i[host_sel] & dev_mask[d]) == dev_base[d]) begin
        dec_hit = 1'b1;
        dev_sel = bus_device_e'(d);
      end
    end
  end

  always_comb begin
    for (int h = 0; h < `SYS_NR_HOSTS; h++) begin
      host_gnt_o[h] = arb_req && (host_sel == bus_host_e'(h));
    end
  end

  // Request fields are broadcast, only req is steered
  always_comb begin
    for (int d = 0; d < `SYS_NR_DEVICES; d++) begin
      dev_req_o[d]   = arb_req && dec_hit && (dev_sel == bus_device_e'(d));
      dev_addr_o[d]  = host_addr_i[host_sel];
      dev_we_o[d]    = host_we_i[host_sel];
      dev_be_o[d]    = host_be_i[host_sel];
      dev_wdata_o[d] = host_wdata_i[host_sel];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      rsp_host_q  <= HostCore;
      rsp_hit_q   <= 1'b0;
      rsp_dev_q   <= DevRam;
    end else begin
      rsp_valid_q <= arb_req;
      rsp_host_q  <= host_sel;
      rsp_hit_q   <= dec_hit;
      rsp_dev_q   <= dev_sel;
    end
  end

  // Route the device answer, or a decode error on a miss
  always_comb begin
    for (int h = 0; h < `SYS_NR_HOSTS; h++) begin
      host_rvalid_o[h] = 1'b0;
      host_rdata_o[h]  = '0;
      host_err_o[h]    = 1'b0;
      if (rsp_valid_q && (rsp_host_q == bus_host_e'(h))) begin
        if (rsp_hit_q) begin
          host_rvalid_o[h] = dev_rvalid_i[rsp_dev_q];
          host_rdata_o[h]  = dev_rdata_i[rsp_dev_q];
          host_err_o[h]    = dev_err_i[rsp_dev_q];
        end else begin
          host_rvalid_o[h] = 1'b1;
          host_err_o[h]    = 1'b1;
        end
      end
    end
  end

endmodule

/* hw/ram_1p.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port word RAM with byte enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sys_defines.svh"

module ram_1p (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`SYS_DATA_W/8-1:0] be_i,
  input  sys_pkg::word_t           addr_i,
  input  sys_pkg::word_t           wdata_i,
  output logic                     rvalid_o,
  output sys_pkg::word_t           rdata_o
);
  import sys_pkg::*;

  localparam int IdxW = $clog2(`SYS_RAM_WORDS);

  word_t           mem [`SYS_RAM_WORDS];
  logic [IdxW-1:0] word_idx;

  // Word index within the window
  assign word_idx = addr_i[IdxW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < `SYS_DATA_W / 8; b++) begin
          if (be_i[b]) begin
            mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      rdata_o <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

/* hw/sim_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Character output and halt register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sys_defines.svh"

module sim_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`SYS_DATA_W/8-1:0] be_i,
  input  sys_pkg::word_t           addr_i,
  input  sys_pkg::word_t           wdata_i,
  output logic                     rvalid_o,
  output sys_pkg::word_t           rdata_o,
  output logic [7:0]               char_o,
  output logic                     char_valid_o,
  output logic                     halt_o
);
  import sys_pkg::*;

  localparam word_t CharOffset = 32'h0000_0000;
  localparam word_t HaltOffset = 32'h0000_0008;

  word_t offset;
  logic  char_wr;
  logic  halt_wr;

  assign offset  = addr_i & ~`SYS_SIMCTRL_MASK;
  assign char_wr = req_i && we_i && be_i[0] && (offset == CharOffset);
  assign halt_wr = req_i && we_i && (offset == HaltOffset);

  // Write only block
  assign rdata_o = '0;

  always_ff @(posedge clk_i) begin
    if (char_wr) begin
      char_o <= wdata_i[7:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o     <= 1'b0;
      char_valid_o <= 1'b0;
      halt_o       <= 1'b0;
    end else begin
      rvalid_o     <= req_i;
      char_valid_o <= char_wr;
      // Sticky until reset
      halt_o       <= halt_o | halt_wr;
    end
  end

endmodule

/* hw/timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine timer, 64-bit count and compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sys_defines.svh"

module timer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`SYS_DATA_W/8-1:0] be_i,
  input  sys_pkg::word_t           addr_i,
  input  sys_pkg::word_t           wdata_i,
  output logic                     rvalid_o,
  output sys_pkg::word_t           rdata_o,
  output logic                     err_o,
  output logic                     irq_o
);
  import sys_pkg::*;

  word_t       offset;
  timer_reg_e  reg_sel;
  logic        reg_hit;
  logic        wr_en;
  word_t       rd_word;
  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtimecmp_d;

  // Replace the enabled byte lanes of a word
  function automatic word_t merge_bytes(word_t old_w, word_t new_w,
                                        logic [`SYS_DATA_W/8-1:0] be);
    word_t res;
    res = old_w;
    for (int b = 0; b < `SYS_DATA_W / 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign offset = addr_i & ~`SYS_TIMER_MASK;

  always_comb begin
    reg_hit = 1'b1;
    reg_sel = MtimeLo;
    case (offset)
      `SYS_TIMER_MTIME_LO:    reg_sel = MtimeLo;
      `SYS_TIMER_MTIME_HI:    reg_sel = MtimeHi;
      `SYS_TIMER_MTIMECMP_LO: reg_sel = MtimecmpLo;
      `SYS_TIMER_MTIMECMP_HI: reg_sel = MtimecmpHi;
      default:                reg_hit = 1'b0;
    endcase
  end

  assign wr_en = req_i && we_i && reg_hit;

  // A write to either mtime half replaces the increment
  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (reg_sel)
        MtimeLo:    mtime_d = {mtime_q[63:32], merge_bytes(mtime_q[31:0], wdata_i, be_i)};
        MtimeHi:    mtime_d = {merge_bytes(mtime_q[63:32], wdata_i, be_i), mtime_q[31:0]};
        MtimecmpLo: mtimecmp_d[31:0] = merge_bytes(mtimecmp_q[31:0], wdata_i, be_i);
        default:    mtimecmp_d[63:32] = merge_bytes(mtimecmp_q[63:32], wdata_i, be_i);
      endcase
    end
  end

  always_comb begin
    case (reg_sel)
      MtimeLo:    rd_word = mtime_q[31:0];
      MtimeHi:    rd_word = mtime_q[63:32];
      MtimecmpLo: rd_word = mtimecmp_q[31:0];
      default:    rd_word = mtimecmp_q[63:32];
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= reg_hit ? rd_word : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      rvalid_o   <= 1'b0;
      err_o      <= 1'b0;
      irq_o      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      rvalid_o   <= req_i;
      err_o      <= req_i && !reg_hit;
      irq_o      <= (mtime_q >= mtimecmp_q);
    end
  end

endmodule

/* hw/simple_system.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level, bus with RAM, sim control and timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sys_defines.svh"

module simple_system (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     h0_req_i,
  input  sys_pkg::word_t           h0_addr_i,
  input  logic                     h0_we_i,
  input  logic [`SYS_DATA_W/8-1:0] h0_be_i,
  input  sys_pkg::word_t           h0_wdata_i,
  output logic                     h0_gnt_o,
  output logic                     h0_rvalid_o,
  output sys_pkg::word_t           h0_rdata_o,
  output logic                     h0_err_o,
  input  logic                     h1_req_i,
  input  sys_pkg::word_t           h1_addr_i,
  input  logic                     h1_we_i,
  input  logic [`SYS_DATA_W/8-1:0] h1_be_i,
  input  sys_pkg::word_t           h1_wdata_i,
  output logic                     h1_gnt_o,
  output logic                     h1_rvalid_o,
  output sys_pkg::word_t           h1_rdata_o,
  output logic                     h1_err_o,
  output logic [7:0]               char_o,
  output logic                     char_valid_o,
  output logic                     halt_o,
  output logic                     irq_o
);
  import sys_pkg::*;

  // Host side
  logic                     host_req    [`SYS_NR_HOSTS];
  word_t                    host_addr   [`SYS_NR_HOSTS];
  logic                     host_we     [`SYS_NR_HOSTS];
  logic [`SYS_DATA_W/8-1:0] host_be     [`SYS_NR_HOSTS];
  word_t                    host_wdata  [`SYS_NR_HOSTS];
  logic                     host_gnt    [`SYS_NR_HOSTS];
  logic                     host_rvalid [`SYS_NR_HOSTS];
  word_t                    host_rdata  [`SYS_NR_HOSTS];
  logic                     host_err    [`SYS_NR_HOSTS];

  // Device side
  logic                     dev_req    [`SYS_NR_DEVICES];
  word_t                    dev_addr   [`SYS_NR_DEVICES];
  logic                     dev_we     [`SYS_NR_DEVICES];
  logic [`SYS_DATA_W/8-1:0] dev_be     [`SYS_NR_DEVICES];
  word_t                    dev_wdata  [`SYS_NR_DEVICES];
  logic                     dev_rvalid [`SYS_NR_DEVICES];
  word_t                    dev_rdata  [`SYS_NR_DEVICES];
  logic                     dev_err    [`SYS_NR_DEVICES];

  assign host_req[HostCore]   = h0_req_i;
  assign host_addr[HostCore]  = h0_addr_i;
  assign host_we[HostCore]    = h0_we_i;
  assign host_be[HostCore]    = h0_be_i;
  assign host_wdata[HostCore] = h0_wdata_i;
  assign h0_gnt_o             = host_gnt[HostCore];
  assign h0_rvalid_o          = host_rvalid[HostCore];
  assign h0_rdata_o           = host_rdata[HostCore];
  assign h0_err_o             = host_err[HostCore];

  assign host_req[HostDebug]   = h1_req_i;
  assign host_addr[HostDebug]  = h1_addr_i;
  assign host_we[HostDebug]    = h1_we_i;
  assign host_be[HostDebug]    = h1_be_i;
  assign host_wdata[HostDebug] = h1_wdata_i;
  assign h1_gnt_o              = host_gnt[HostDebug];
  assign h1_rvalid_o           = host_rvalid[HostDebug];
  assign h1_rdata_o            = host_rdata[HostDebug];
  assign h1_err_o              = host_err[HostDebug];

  // Only the timer reports errors
  assign dev_err[DevRam]     = 1'b0;
  assign dev_err[DevSimCtrl] = 1'b0;

  bus u_bus (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .dev_req_o     (dev_req),
    .dev_addr_o    (dev_addr),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_wdata_o   (dev_wdata),
    .dev_rvalid_i  (dev_rvalid),
    .dev_rdata_i   (dev_rdata),
    .dev_err_i     (dev_err)
  );

  ram_1p u_ram (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (dev_req[DevRam]),
    .we_i     (dev_we[DevRam]),
    .be_i     (dev_be[DevRam]),
    .addr_i   (dev_addr[DevRam]),
    .wdata_i  (dev_wdata[DevRam]),
    .rvalid_o (dev_rvalid[DevRam]),
    .rdata_o  (dev_rdata[DevRam])
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (dev_req[DevSimCtrl]),
    .we_i         (dev_we[DevSimCtrl]),
    .be_i         (dev_be[DevSimCtrl]),
    .addr_i       (dev_addr[DevSimCtrl]),
    .wdata_i      (dev_wdata[DevSimCtrl]),
    .rvalid_o     (dev_rvalid[DevSimCtrl]),
    .rdata_o      (dev_rdata[DevSimCtrl]),
    .char_o       (char_o),
    .char_valid_o (char_valid_o),
    .halt_o       (halt_o)
  );

  timer u_timer (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (dev_req[DevTimer]),
    .we_i     (dev_we[DevTimer]),
    .be_i     (dev_be[DevTimer]),
    .addr_i   (dev_addr[DevTimer]),
    .wdata_i  (dev_wdata[DevTimer]),
    .rvalid_o (dev_rvalid[DevTimer]),
    .rdata_o  (dev_rdata[DevTimer]),
    .err_o    (dev_err[DevTimer]),
    .irq_o    (irq_o)
  );

endmodule

/* tests/tb_simple_system.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench with shadow RAM, watchdog and typed checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sys_defines.svh"

module tb_simple_system;
  import sys_pkg::*;

  // How the read data of a row is judged
  typedef enum logic [2:0] {
    ChkNone,
    ChkExact,
    ChkShadow,
    ChkMtimeFirst,
    ChkMtimeLater
  } chk_e;

  typedef enum logic [1:0] {
    IrqIgnore,
    IrqLow,
    IrqRise
  } irq_e;

  typedef struct packed {
    bus_host_e                host;
    logic                     with_next;
    logic                     we;
    word_t                    addr;
    logic [`SYS_DATA_W/8-1:0] be;
    word_t                    wdata;
    chk_e                     chk;
    word_t                    exp_rdata;
    logic                     exp_err;
    logic                     exp_char;
    logic                     exp_halt;
    irq_e                     irq;
  } row_t;

  localparam int IrqCmp = 20;

  logic                     clk_i;
  logic                     rst_i;
  logic                     h0_req_i, h0_we_i, h1_req_i, h1_we_i;
  logic [`SYS_DATA_W/8-1:0] h0_be_i, h1_be_i;
  word_t                    h0_addr_i, h0_wdata_i, h1_addr_i, h1_wdata_i;
  logic                     h0_gnt_o, h0_rvalid_o, h0_err_o;
  logic                     h1_gnt_o, h1_rvalid_o, h1_err_o;
  word_t                    h0_rdata_o, h1_rdata_o;
  logic [7:0]               char_o;
  logic                     char_valid_o, halt_o, irq_o;

  row_t  table_q [$];
  word_t shadow [word_t];
  logic  table_ready = 1'b0;
  logic  halt_expected = 1'b0;
  word_t mtime_first;
  int    mtime_first_row;
  int    mtime_wr_cycle;
  int    cycle_cnt = 0;

  simple_system dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic report_mismatch(string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_word(string what, word_t act, word_t exp);
    if (act !== exp) begin
      report_mismatch($sformatf("%s is %h, expected %h", what, act, exp));
    end
  endtask

  task automatic check_flag(string what, logic act, logic exp);
    if (act !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", what, act, exp));
    end
  endtask

  task automatic check_byte(string what, logic [7:0] act, logic [7:0] exp);
    if (act !== exp) begin
      report_mismatch($sformatf("%s is %h, expected %h", what, act, exp));
    end
  endtask

  // Byte lanes of new_w replace those of old_w
  function automatic word_t merge_lanes(word_t old_w, word_t new_w,
                                        logic [`SYS_DATA_W/8-1:0] be);
    word_t mask;
    for (int b = 0; b < `SYS_DATA_W / 8; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic word_t ram_addr(int idx);
    return `SYS_RAM_BASE + (word_t'(idx) << 2);
  endfunction

  function automatic row_t make_row(bus_host_e host, logic we, word_t addr,
                                    logic [`SYS_DATA_W/8-1:0] be, word_t wdata,
                                    chk_e chk, word_t exp_rdata, logic exp_err);
    row_t r;
    r           = '0;
    r.host      = host;
    r.we        = we;
    r.addr      = addr;
    r.be        = be;
    r.wdata     = wdata;
    r.chk       = chk;
    r.exp_rdata = exp_rdata;
    r.exp_err   = exp_err;
    return r;
  endfunction

  function automatic logic host_gnt(bus_host_e host);
    return (host == HostCore) ? h0_gnt_o : h1_gnt_o;
  endfunction

  function automatic logic host_rvalid(bus_host_e host);
    return (host == HostCore) ? h0_rvalid_o : h1_rvalid_o;
  endfunction

  task automatic drive_host(bus_host_e host, logic req, row_t r);
    if (host == HostCore) begin
      h0_req_i   <= req;
      h0_addr_i  <= r.addr;
      h0_we_i    <= r.we;
      h0_be_i    <= r.be;
      h0_wdata_i <= r.wdata;
    end else begin
      h1_req_i   <= req;
      h1_addr_i  <= r.addr;
      h1_we_i    <= r.we;
      h1_be_i    <= r.be;
      h1_wdata_i <= r.wdata;
    end
  endtask

  // Sampled at the falling edge of the cycle after the grant
  task automatic check_response(int idx);
    row_t  r;
    logic  err;
    word_t rdata;
    word_t key;
    r     = table_q[idx];
    err   = (r.host == HostCore) ? h0_err_o : h1_err_o;
    rdata = (r.host == HostCore) ? h0_rdata_o : h1_rdata_o;
    key   = r.addr & ~32'h3;
    check_flag($sformatf("row %0d rvalid", idx), host_rvalid(r.host), 1'b1);
    check_flag($sformatf("row %0d err", idx), err, r.exp_err);
    case (r.chk)
      ChkExact:  check_word($sformatf("row %0d rdata", idx), rdata, r.exp_rdata);
      ChkShadow: check_word($sformatf("row %0d RAM rdata", idx), rdata, shadow[key]);
      ChkMtimeFirst: begin
        mtime_first     = rdata;
        mtime_first_row = idx;
      end
      ChkMtimeLater: begin
        check_flag($sformatf("row %0d mtime_lo %h advanced from %h", idx, rdata, mtime_first),
                   rdata > mtime_first
                   && (rdata - mtime_first) >= word_t'(idx - mtime_first_row - 1), 1'b1);
      end
      default: ;
    endcase
    if (r.we && !r.exp_err && ((r.addr & `SYS_RAM_MASK) == `SYS_RAM_BASE)) begin
      shadow[key] = merge_lanes(shadow[key], r.wdata, r.be);
    end
    if (r.we && !r.exp_err && r.addr == `SYS_TIMER_BASE + `SYS_TIMER_MTIME_LO) begin
      mtime_wr_cycle = cycle_cnt;
    end
    check_flag($sformatf("row %0d char_valid_o", idx), char_valid_o, r.exp_char);
    if (r.exp_char) begin
      check_byte($sformatf("row %0d char_o", idx), char_o, r.wdata[7:0]);
    end
    if (r.exp_halt) begin
      halt_expected = 1'b1;
    end
    check_flag($sformatf("row %0d halt_o", idx), halt_o, halt_expected);
    if (r.irq == IrqRise) begin
      check_flag("irq_o before mtime reaches mtimecmp", irq_o, 1'b0);
      while (!irq_o && (cycle_cnt - mtime_wr_cycle) <= IrqCmp + 3) begin
        @(negedge clk_i);
      end
      check_flag("irq_o within N+3 cycles of the mtime write", irq_o, 1'b1);
      check_flag("irq_o held low until mtime reaches mtimecmp",
                 (cycle_cnt - mtime_wr_cycle) > IrqCmp, 1'b1);
    end else if (r.irq == IrqLow) begin
      // The level follows the new compare one cycle later
      @(negedge clk_i);
      check_flag("irq_o after mtimecmp raised", irq_o, 1'b0);
    end
  endtask

  task automatic run_single(int idx);
    row_t r;
    r = table_q[idx];
    @(posedge clk_i);
    drive_host(r.host, 1'b1, r);
    @(negedge clk_i);
    while (!host_gnt(r.host)) begin
      @(negedge clk_i);
    end
    check_flag($sformatf("row %0d rvalid in grant cycle", idx), host_rvalid(r.host), 1'b0);
    @(posedge clk_i);
    drive_host(r.host, 1'b0, r);
    @(negedge clk_i);
    check_response(idx);
  endtask

  // Both hosts request together, host 1 holds its fields until granted
  task automatic run_pair(int idx);
    row_t a;
    row_t b;
    a = table_q[idx];
    b = table_q[idx + 1];
    @(posedge clk_i);
    drive_host(HostCore, 1'b1, a);
    drive_host(HostDebug, 1'b1, b);
    @(negedge clk_i);
    check_flag("h0_gnt_o with both requesting", h0_gnt_o, 1'b1);
    check_flag("h1_gnt_o with both requesting", h1_gnt_o, 1'b0);
    @(posedge clk_i);
    drive_host(HostCore, 1'b0, a);
    @(negedge clk_i);
    check_response(idx);
    check_flag("h1_gnt_o after host 0 is served", h1_gnt_o, 1'b1);
    @(posedge clk_i);
    drive_host(HostDebug, 1'b0, b);
    @(negedge clk_i);
    check_response(idx + 1);
  endtask

  task automatic build_table();
    row_t r;
    word_t tmr;
    word_t sc;
    tmr = `SYS_TIMER_BASE;
    sc  = `SYS_SIMCTRL_BASE;
    // RAM full and partial writes, readback from both hosts
    table_q.push_back(make_row(HostCore, 1'b1, ram_addr(0), 4'hF, $urandom(), ChkNone, '0, 1'b0));
    table_q.push_back(make_row(HostCore, 1'b1, ram_addr(1), 4'hF, $urandom(), ChkNone, '0, 1'b0));
    table_q.push_back(make_row(HostCore, 1'b1, ram_addr(1), 4'h5, $urandom(), ChkNone, '0, 1'b0));
    table_q.push_back(make_row(HostDebug, 1'b1, ram_addr(2), 4'hF, $urandom(), ChkNone, '0, 1'b0));
    table_q.push_back(make_row(HostDebug, 1'b1, ram_addr(2), 4'h8, $urandom(), ChkNone, '0, 1'b0));
    table_q.push_back(make_row(HostDebug, 1'b0, ram_addr(0), 4'hF, '0, ChkShadow, '0, 1'b0));
    table_q.push_back(make_row(HostCore, 1'b0, ram_addr(1), 4'hF, '0, ChkShadow, '0, 1'b0));
    table_q.push_back(make_row(HostDebug, 1'b0, ram_addr(2), 4'hF, '0, ChkShadow, '0, 1'b0));
    table_q.push_back(make_row(HostCore, 1'b0, tmr, 4'hF, '0, ChkMtimeFirst, '0, 1'b0));
    // Simultaneous requests
    r = make_row(HostCore, 1'b1, ram_addr(5), 4'hF, $urandom(), ChkNone, '0, 1'b0);
    r.with_next = 1'b1;
    table_q.push_back(r);
    table_q.push_back(make_row(HostDebug, 1'b0, ram_addr(5), 4'hF, '0, ChkShadow, '0, 1'b0));
    r = make_row(HostCore, 1'b0, ram_addr(1), 4'hF, '0, ChkShadow, '0, 1'b0);
    r.with_next = 1'b1;
    table_q.push_back(r);
    table_q.push_back(make_row(HostDebug, 1'b1, ram_addr(3), 4'hF, $urandom(), ChkNone, '0, 1'b0));
    table_q.push_back(make_row(HostCore, 1'b0, ram_addr(3), 4'hF, '0, ChkShadow, '0, 1'b0));
    table_q.push_back(make_row(HostDebug, 1'b0, tmr, 4'hF, '0, ChkMtimeLater, '0, 1'b0));
    // Decode misses and a missing timer offset
    table_q.push_back(make_row(HostCore, 1'b1, 32'h0010_1000, 4'hF, 32'hDEAD_BEEF, ChkNone, '0,
                               1'b1));
    table_q.push_back(make_row(HostDebug, 1'b0, 32'h0000_4000, 4'hF, '0, ChkNone, '0, 1'b1));
    table_q.push_back(make_row(HostCore, 1'b0, tmr + 32'h10, 4'hF, '0, ChkNone, '0, 1'b1));
    table_q.push_back(make_row(HostCore, 1'b0, ram_addr(0), 4'hF, '0, ChkShadow, '0, 1'b0));
    // Characters
    r = make_row(HostCore, 1'b1, sc, 4'h1, 32'h0000_0048, ChkNone, '0, 1'b0);
    r.exp_char = 1'b1;
    table_q.push_back(r);
    r = make_row(HostDebug, 1'b1, sc, 4'hF, 32'h0000_0069, ChkNone, '0, 1'b0);
    r.exp_char = 1'b1;
    table_q.push_back(r);
    // Timer compare and interrupt
    table_q.push_back(make_row(HostCore, 1'b1, tmr, 4'hF, '0, ChkNone, '0, 1'b0));
    table_q.push_back(make_row(HostCore, 1'b1, tmr + 32'hC, 4'hF, '0, ChkNone, '0, 1'b0));
    r = make_row(HostCore, 1'b1, tmr + 32'h8, 4'hF, word_t'(IrqCmp), ChkNone, '0, 1'b0);
    r.irq = IrqRise;
    table_q.push_back(r);
    r = make_row(HostCore, 1'b1, tmr + 32'hC, 4'hF, 32'hFFFF_FFFF, ChkNone, '0, 1'b0);
    r.irq = IrqLow;
    table_q.push_back(r);
    table_q.push_back(make_row(HostCore, 1'b0, tmr + 32'hC, 4'hF, '0, ChkExact, 32'hFFFF_FFFF,
                               1'b0));
    // Halt is sticky
    r = make_row(HostDebug, 1'b1, sc + 32'h8, 4'hF, 32'h1, ChkNone, '0, 1'b0);
    r.exp_halt = 1'b1;
    table_q.push_back(r);
    table_q.push_back(make_row(HostCore, 1'b0, ram_addr(2), 4'hF, '0, ChkShadow, '0, 1'b0));
  endtask

  initial begin
    int limit;
    wait (table_ready);
    limit = table_q.size() * 40 + 200;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the stimulus table did not finish within %0d clock cycles", limit);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int   idx;
    row_t cur;
    rst_i      = 1'b1;
    h0_req_i   = 1'b0;
    h0_addr_i  = '0;
    h0_we_i    = 1'b0;
    h0_be_i    = '0;
    h0_wdata_i = '0;
    h1_req_i   = 1'b0;
    h1_addr_i  = '0;
    h1_we_i    = 1'b0;
    h1_be_i    = '0;
    h1_wdata_i = '0;
    void'($urandom(32'ha530_c03d));
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_flag("h0_gnt_o after reset", h0_gnt_o, 1'b0);
    check_flag("h1_gnt_o after reset", h1_gnt_o, 1'b0);
    check_flag("h0_rvalid_o after reset", h0_rvalid_o, 1'b0);
    check_flag("h1_rvalid_o after reset", h1_rvalid_o, 1'b0);
    check_flag("h0_err_o after reset", h0_err_o, 1'b0);
    check_flag("h1_err_o after reset", h1_err_o, 1'b0);
    check_flag("char_valid_o after reset", char_valid_o, 1'b0);
    check_flag("halt_o after reset", halt_o, 1'b0);
    check_flag("irq_o after reset", irq_o, 1'b0);
    idx = 0;
    while (idx < table_q.size()) begin
      cur = table_q[idx];
      if (cur.with_next) begin
        run_pair(idx);
        idx = idx + 2;
      end else begin
        run_single(idx);
        idx = idx + 1;
      end
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+hw
hw/sys_pkg.sv
hw/bus.sv
hw/ram_1p.sv
hw/sim_ctrl.sv
hw/timer.sv
hw/simple_system.sv
tests/tb_simple_system.sv

/* Makefile */
# Verilator build and run of the bus system testbench

VERILATOR ?= verilator
TOP       ?= tb_simple_system
BUILD_DIR ?= build
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(FILELIST) $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, BUILD_DIR, FILELIST, VFLAGS"

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
